// ==== verilog/simba_settings.svh ====
// Widths, CSR map split and CSR reset value of the multiply shell
// TCDM addresses count 32-bit words, not bytes
// Changing SIMBA_DATA_W also changes the product width in the core
`ifndef SIMBA_SETTINGS_SVH
`define SIMBA_SETTINGS_SVH

// --------------------
// Widths
// --------------------
// CSR and TCDM data word
`define SIMBA_DATA_W 32
// TCDM word address
`define SIMBA_TCDM_AW 12
`define SIMBA_CSR_AW 8
// Right shift applied to the 64-bit product
`define SIMBA_SHIFT_W 5

// --------------------
// CSR map
// --------------------
// First streamer CSR, manager CSRs sit below it
`define SIMBA_ADDR_SEL_OFFSET 16
// Reset value of every CSR
`define SIMBA_CSR_RST 32'h0000_0000

`endif

// ==== verilog/simba_pkg.sv ====
// Shared types of the multiply shell
// Streamer CSR indices are relative to the select offset
`default_nettype none

`include "simba_settings.svh"

package simba_pkg;

  // Data and address words
  typedef logic [`SIMBA_DATA_W-1:0]  data_t;
  typedef logic [`SIMBA_TCDM_AW-1:0] tcdm_addr_t;
  typedef logic [`SIMBA_CSR_AW-1:0]  csr_addr_t;
  // Result shift amount
  typedef logic [`SIMBA_SHIFT_W-1:0] shift_t;

  // Manager CSRs, below the select offset
  typedef enum logic [`SIMBA_CSR_AW-1:0] {
    MGR_CTRL       = 0,  // write 1 starts a job
    MGR_SHIFT      = 1,
    MGR_STATUS     = 2,  // bit 0 busy
    MGR_DONE_COUNT = 3
  } mgr_csr_e;

  // Streamer CSRs, rebased by the demux
  typedef enum logic [`SIMBA_CSR_AW-1:0] {
    STR_BASE_A = 0,
    STR_BASE_B = 1,
    STR_BASE_C = 2,
    STR_LENGTH = 3
  } str_csr_e;

endpackage

`default_nettype wire

// ==== verilog/csr_bus_if.sv ====
// One CSR request/response channel
// Every request gets exactly one response, write responses carry 0
`timescale 1ns/10ps
`default_nettype none

interface csr_bus_if;
  import simba_pkg::*;

  // Request side
  csr_addr_t addr;
  data_t     wdata;
  logic      write;
  logic      req_valid;
  logic      req_ready;

  // Response side
  data_t     rsp_data;
  logic      rsp_valid;
  logic      rsp_ready;

  // Host or demux side
  modport requester (
    output addr, wdata, write, req_valid, rsp_ready,
    input  req_ready, rsp_data, rsp_valid
  );

  // CSR block side
  modport responder (
    input  addr, wdata, write, req_valid, rsp_ready,
    output req_ready, rsp_data, rsp_valid
  );

endinterface

`default_nettype wire

// ==== verilog/csr_demux.sv ====
// Splits host CSR traffic between manager and streamer by address
// One request outstanding at a time, response passes through combinationally
// Ready stays low until the first cycle out of reset
`timescale 1ns/10ps
`default_nettype none

`include "simba_settings.svh"

module csr_demux (
  input  wire logic    clk_i,
  input  wire logic    rst_n_i,
  csr_bus_if.responder host,
  csr_bus_if.requester to_mgr,
  csr_bus_if.requester to_str
);
  import simba_pkg::*;

  logic live_q;      // out of reset
  logic pend_q;      // response owed to host
  logic pend_str_q;  // streamer owes it
  logic sel_str;
  logic tgt_ready;
  logic open;

  // Address split
  assign sel_str   = (host.addr >= csr_addr_t'(`SIMBA_ADDR_SEL_OFFSET));
  assign tgt_ready = sel_str ? to_str.req_ready : to_mgr.req_ready;
  // Free to forward a new request
  assign open      = live_q & ~pend_q;

  assign host.req_ready = open & tgt_ready;

  // --------------------
  // Request fan-out
  // --------------------
  assign to_mgr.addr      = host.addr;
  assign to_mgr.wdata     = host.wdata;
  assign to_mgr.write     = host.write;
  assign to_mgr.req_valid = host.req_valid & open & ~sel_str;

  // Streamer sees indices from zero
  assign to_str.addr      = host.addr - csr_addr_t'(`SIMBA_ADDR_SEL_OFFSET);
  assign to_str.wdata     = host.wdata;
  assign to_str.write     = host.write;
  assign to_str.req_valid = host.req_valid & open & sel_str;

  // --------------------
  // Response mux
  // --------------------
  assign host.rsp_valid   = pend_q & (pend_str_q ? to_str.rsp_valid : to_mgr.rsp_valid);
  assign host.rsp_data    = pend_str_q ? to_str.rsp_data : to_mgr.rsp_data;
  assign to_mgr.rsp_ready = pend_q & ~pend_str_q & host.rsp_ready;
  assign to_str.rsp_ready = pend_q & pend_str_q & host.rsp_ready;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      live_q     <= 1'b0;
      pend_q     <= 1'b0;
      pend_str_q <= 1'b0;
    end else begin
      live_q <= 1'b1;
      // Remember who owes the response
      if (host.req_valid && host.req_ready) begin
        pend_q     <= 1'b1;
        pend_str_q <= sel_str;
      end else if (host.rsp_valid && host.rsp_ready) begin
        pend_q <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/csr_manager.sv ====
// Accelerator CSRs and job sequencing
// A CTRL write while busy is dropped, not queued
// Response comes one cycle after accept and is held until taken
`timescale 1ns/10ps
`default_nettype none

`include "simba_settings.svh"

module csr_manager (
  input  wire logic         clk_i,
  input  wire logic         rst_n_i,
  csr_bus_if.responder      csr,
  input  wire logic         done_i,
  output logic              start_o,
  output simba_pkg::shift_t shift_o
);
  import simba_pkg::*;

  shift_t shift_q;
  logic   busy_q;
  data_t  done_cnt_q;
  logic   rsp_valid_q;
  data_t  rsp_data_q;
  data_t  rd_data;
  logic   req_fire;
  logic   ctrl_start;

  assign req_fire      = csr.req_valid & csr.req_ready;
  // One request at a time
  assign csr.req_ready = ~rsp_valid_q;
  assign csr.rsp_valid = rsp_valid_q;
  assign csr.rsp_data  = rsp_data_q;
  assign shift_o       = shift_q;

  // Start only from idle
  assign ctrl_start = req_fire & csr.write & (csr.addr == MGR_CTRL)
                    & csr.wdata[0] & ~busy_q;

  // Read-back, unmapped and CTRL read as 0
  always_comb begin
    case (csr.addr)
      MGR_SHIFT:      rd_data = data_t'(shift_q);
      MGR_STATUS:     rd_data = data_t'(busy_q);
      MGR_DONE_COUNT: rd_data = done_cnt_q;
      default:        rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      shift_q     <= shift_t'(`SIMBA_CSR_RST);
      busy_q      <= 1'b0;
      done_cnt_q  <= data_t'(`SIMBA_CSR_RST);
      start_o     <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      // One-cycle start pulse
      start_o <= ctrl_start;
      if (ctrl_start) begin
        busy_q <= 1'b1;
      end else if (done_i) begin
        busy_q <= 1'b0;
      end
      // Completed jobs
      if (done_i) begin
        done_cnt_q <= done_cnt_q + data_t'(1);
      end
      if (req_fire && csr.write && (csr.addr == MGR_SHIFT)) begin
        shift_q <= csr.wdata[`SIMBA_SHIFT_W-1:0];
      end
      // Response handshake
      if (req_fire) begin
        rsp_valid_q <= 1'b1;
      end else if (csr.rsp_ready) begin
        rsp_valid_q <= 1'b0;
      end
    end
  end

  // Write responses carry 0
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      rsp_data_q <= csr.write ? '0 : rd_data;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/tcdm_streamer.sv ====
// Streamer CSRs and TCDM sequencing of one multiply job
// Reads A then B per index, writes results to BASE_C, writes win the port
// Read responses must come back in order, one per read
`timescale 1ns/10ps
`default_nettype none

`include "simba_settings.svh"

module tcdm_streamer (
  input  wire logic              clk_i,
  input  wire logic              rst_n_i,
  csr_bus_if.responder           csr,
  input  wire logic              start_i,
  output logic                   done_o,
  output logic                   tcdm_req_valid_o,
  input  wire logic              tcdm_req_ready_i,
  output logic                   tcdm_write_o,
  output simba_pkg::tcdm_addr_t  tcdm_addr_o,
  output simba_pkg::data_t       tcdm_wdata_o,
  input  wire logic              tcdm_rsp_valid_i,
  input  wire simba_pkg::data_t  tcdm_rsp_data_i,
  output simba_pkg::data_t       op_a_o,
  output simba_pkg::data_t       op_b_o,
  output logic                   op_valid_o,
  input  wire logic              op_ready_i,
  input  wire simba_pkg::data_t  res_i,
  input  wire logic              res_valid_i,
  output logic                   res_ready_o
);
  import simba_pkg::*;

  // CSR state
  data_t base_a_q;
  data_t base_b_q;
  data_t base_c_q;
  data_t len_q;
  logic  rsp_valid_q;
  data_t rsp_data_q;
  data_t rd_data;
  logic  req_fire;

  // Job state
  logic       active_q;
  logic       rd_b_q;      // next read is B
  logic       rsp_b_q;     // next response is B
  logic       b_out_q;     // B read not yet answered
  logic       req_last_q;  // request in flight is the last write
  data_t      rd_idx_q;
  data_t      wr_idx_q;
  data_t      a_hold_q;
  logic       port_free;
  logic       rd_go;
  logic       wr_go;
  logic       wr_fire;
  tcdm_addr_t rd_addr;
  tcdm_addr_t wr_addr;

  // --------------------
  // CSR access
  // --------------------
  assign req_fire      = csr.req_valid & csr.req_ready;
  assign csr.req_ready = ~rsp_valid_q;
  assign csr.rsp_valid = rsp_valid_q;
  assign csr.rsp_data  = rsp_data_q;

  always_comb begin
    case (csr.addr)
      STR_BASE_A: rd_data = base_a_q;
      STR_BASE_B: rd_data = base_b_q;
      STR_BASE_C: rd_data = base_c_q;
      STR_LENGTH: rd_data = len_q;
      default:    rd_data = '0;
    endcase
  end

  // --------------------
  // Port arbitration
  // --------------------
  // Request register empty or draining
  assign port_free   = ~tcdm_req_valid_o | tcdm_req_ready_i;
  assign res_ready_o = active_q & port_free;
  assign wr_go       = res_valid_i & res_ready_o;
  assign wr_fire     = tcdm_req_valid_o & tcdm_req_ready_i & tcdm_write_o;
  // B waits for the operand slot so its response has a place to land
  assign rd_go = active_q & (rd_idx_q < len_q) & (~rd_b_q | (~op_valid_o & ~b_out_q));

  assign rd_addr = (rd_b_q ? base_b_q[`SIMBA_TCDM_AW-1:0] : base_a_q[`SIMBA_TCDM_AW-1:0])
                 + rd_idx_q[`SIMBA_TCDM_AW-1:0];
  assign wr_addr = base_c_q[`SIMBA_TCDM_AW-1:0] + wr_idx_q[`SIMBA_TCDM_AW-1:0];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      base_a_q         <= data_t'(`SIMBA_CSR_RST);
      base_b_q         <= data_t'(`SIMBA_CSR_RST);
      base_c_q         <= data_t'(`SIMBA_CSR_RST);
      len_q            <= data_t'(`SIMBA_CSR_RST);
      rsp_valid_q      <= 1'b0;
      active_q         <= 1'b0;
      done_o           <= 1'b0;
      tcdm_req_valid_o <= 1'b0;
      tcdm_write_o     <= 1'b0;
      rd_b_q           <= 1'b0;
      rsp_b_q          <= 1'b0;
      b_out_q          <= 1'b0;
      req_last_q       <= 1'b0;
      op_valid_o       <= 1'b0;
      rd_idx_q         <= '0;
      wr_idx_q         <= '0;
    end else begin
      if (req_fire && csr.write) begin
        case (csr.addr)
          STR_BASE_A: base_a_q <= csr.wdata;
          STR_BASE_B: base_b_q <= csr.wdata;
          STR_BASE_C: base_c_q <= csr.wdata;
          STR_LENGTH: len_q    <= csr.wdata;
          default:    ;
        endcase
      end
      if (req_fire) begin
        rsp_valid_q <= 1'b1;
      end else if (csr.rsp_ready) begin
        rsp_valid_q <= 1'b0;
      end
      done_o <= 1'b0;
      // Load next request, write first
      if (port_free) begin
        tcdm_req_valid_o <= wr_go | rd_go;
        tcdm_write_o     <= wr_go;
      end
      if (wr_go) begin
        wr_idx_q   <= wr_idx_q + data_t'(1);
        req_last_q <= (wr_idx_q == len_q - data_t'(1));
      end else if (port_free && rd_go) begin
        rd_b_q <= ~rd_b_q;
        if (rd_b_q) begin
          rd_idx_q <= rd_idx_q + data_t'(1);
          b_out_q  <= 1'b1;
        end
      end
      // Responses alternate A, B
      if (op_valid_o && op_ready_i) begin
        op_valid_o <= 1'b0;
      end
      if (tcdm_rsp_valid_i) begin
        rsp_b_q <= ~rsp_b_q;
        if (rsp_b_q) begin
          b_out_q    <= 1'b0;
          op_valid_o <= 1'b1;
        end
      end
      // Last write gone, job over
      if (wr_fire && req_last_q) begin
        active_q <= 1'b0;
        done_o   <= 1'b1;
      end
      // Zero length finishes at once
      if (start_i) begin
        active_q <= (len_q != '0);
        done_o   <= (len_q == '0);
        rd_idx_q <= '0;
        wr_idx_q <= '0;
        rd_b_q   <= 1'b0;
        rsp_b_q  <= 1'b0;
        b_out_q  <= 1'b0;
      end
    end
  end

  // Payload registers
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      rsp_data_q <= csr.write ? '0 : rd_data;
    end
    if (port_free) begin
      tcdm_addr_o  <= wr_go ? wr_addr : rd_addr;
      tcdm_wdata_o <= res_i;
    end
    if (tcdm_rsp_valid_i) begin
      if (rsp_b_q) begin
        op_a_o <= a_hold_q;
        op_b_o <= tcdm_rsp_data_i;
      end else begin
        a_hold_q <= tcdm_rsp_data_i;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/mul_core.sv ====
// Two-stage unsigned multiply, shift right, keep the low word
// Full stall: res_ready low freezes both stages and drops op_ready
`timescale 1ns/10ps
`default_nettype none

`include "simba_settings.svh"

module mul_core (
  input  wire logic              clk_i,
  input  wire logic              rst_n_i,
  input  wire simba_pkg::shift_t shift_i,
  input  wire simba_pkg::data_t  op_a_i,
  input  wire simba_pkg::data_t  op_b_i,
  input  wire logic              op_valid_i,
  output logic                   op_ready_o,
  output simba_pkg::data_t       res_o,
  output logic                   res_valid_o,
  input  wire logic              res_ready_i
);
  import simba_pkg::*;

  // Full-width product
  typedef logic [2*`SIMBA_DATA_W-1:0] prod_t;

  prod_t prod_q;
  logic  s1_valid_q;

  // Pipe moves only when the output can drain
  assign op_ready_o = res_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      s1_valid_q  <= 1'b0;
      res_valid_o <= 1'b0;
    end else if (res_ready_i) begin
      s1_valid_q  <= op_valid_i;
      res_valid_o <= s1_valid_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (res_ready_i) begin
      // Stage 1 product, stage 2 shift and truncate
      prod_q <= prod_t'(op_a_i) * prod_t'(op_b_i);
      res_o  <= data_t'(prod_q >> shift_i);
    end
  end

endmodule

`default_nettype wire

// ==== verilog/simba_top.sv ====
// Multiply shell top, host CSR and TCDM ports are plain signals
// Host CSRs below SIMBA_ADDR_SEL_OFFSET belong to the manager
`timescale 1ns/10ps
`default_nettype none

module simba_top (
  input  wire logic                 clk_i,
  input  wire logic                 rst_n_i,
  // Host CSR request
  input  wire simba_pkg::csr_addr_t csr_addr_i,
  input  wire simba_pkg::data_t     csr_wdata_i,
  input  wire logic                 csr_write_i,
  input  wire logic                 csr_req_valid_i,
  output logic                      csr_req_ready_o,
  // Host CSR response
  output simba_pkg::data_t          csr_rsp_data_o,
  output logic                      csr_rsp_valid_o,
  input  wire logic                 csr_rsp_ready_i,
  // TCDM port
  output logic                      tcdm_req_valid_o,
  input  wire logic                 tcdm_req_ready_i,
  output logic                      tcdm_write_o,
  output simba_pkg::tcdm_addr_t     tcdm_addr_o,
  output simba_pkg::data_t          tcdm_wdata_o,
  input  wire logic                 tcdm_rsp_valid_i,
  input  wire simba_pkg::data_t     tcdm_rsp_data_i
);
  import simba_pkg::*;

  csr_bus_if host_bus ();
  csr_bus_if mgr_bus ();
  csr_bus_if str_bus ();

  logic   start;
  logic   done;
  shift_t shift;
  data_t  op_a;
  data_t  op_b;
  logic   op_valid;
  logic   op_ready;
  data_t  res;
  logic   res_valid;
  logic   res_ready;

  // Host pins onto the bus
  assign host_bus.addr      = csr_addr_i;
  assign host_bus.wdata     = csr_wdata_i;
  assign host_bus.write     = csr_write_i;
  assign host_bus.req_valid = csr_req_valid_i;
  assign host_bus.rsp_ready = csr_rsp_ready_i;
  assign csr_req_ready_o    = host_bus.req_ready;
  assign csr_rsp_data_o     = host_bus.rsp_data;
  assign csr_rsp_valid_o    = host_bus.rsp_valid;

  // --------------------
  // Control
  // --------------------
  csr_demux i_csr_demux (
    .clk_i   ( clk_i    ),
    .rst_n_i ( rst_n_i  ),
    .host    ( host_bus ),
    .to_mgr  ( mgr_bus  ),
    .to_str  ( str_bus  )
  );

  csr_manager i_csr_manager (
    .clk_i   ( clk_i   ),
    .rst_n_i ( rst_n_i ),
    .csr     ( mgr_bus ),
    .done_i  ( done    ),
    .start_o ( start   ),
    .shift_o ( shift   )
  );

  // --------------------
  // Datapath
  // --------------------
  tcdm_streamer i_tcdm_streamer (
    .clk_i            ( clk_i            ),
    .rst_n_i          ( rst_n_i          ),
    .csr              ( str_bus          ),
    .start_i          ( start            ),
    .done_o           ( done             ),
    .tcdm_req_valid_o ( tcdm_req_valid_o ),
    .tcdm_req_ready_i ( tcdm_req_ready_i ),
    .tcdm_write_o     ( tcdm_write_o     ),
    .tcdm_addr_o      ( tcdm_addr_o      ),
    .tcdm_wdata_o     ( tcdm_wdata_o     ),
    .tcdm_rsp_valid_i ( tcdm_rsp_valid_i ),
    .tcdm_rsp_data_i  ( tcdm_rsp_data_i  ),
    .op_a_o           ( op_a             ),
    .op_b_o           ( op_b             ),
    .op_valid_o       ( op_valid         ),
    .op_ready_i       ( op_ready         ),
    .res_i            ( res              ),
    .res_valid_i      ( res_valid        ),
    .res_ready_o      ( res_ready        )
  );

  mul_core i_mul_core (
    .clk_i       ( clk_i     ),
    .rst_n_i     ( rst_n_i   ),
    .shift_i     ( shift     ),
    .op_a_i      ( op_a      ),
    .op_b_i      ( op_b      ),
    .op_valid_i  ( op_valid  ),
    .op_ready_o  ( op_ready  ),
    .res_o       ( res       ),
    .res_valid_o ( res_valid ),
    .res_ready_i ( res_ready )
  );

endmodule

`default_nettype wire

// ==== tests/simba_tb.sv ====
// Must run from the project root to find the stimulus file
// Stimulus holds seven hex fields per job
// TCDM model is 4096 words with random grant and random CSR response ready
`timescale 1ns/10ps
`default_nettype none

module simba_tb;

  localparam int MEM_WORDS       = 4096;
  localparam int NUM_JOBS        = 6;
  localparam int NUM_FIELDS      = 7;
  localparam int CYCLES_PER_ELEM = 20;
  // Room for CSR traffic and polling
  localparam int MARGIN_CYCLES   = 4000;

  // Manager CSRs
  localparam logic [7:0] MGR_CTRL       = 8'd0;
  localparam logic [7:0] MGR_SHIFT      = 8'd1;
  localparam logic [7:0] MGR_STATUS     = 8'd2;
  localparam logic [7:0] MGR_DONE_COUNT = 8'd3;
  // Streamer CSRs start at 16
  localparam logic [7:0] STR_BASE_A     = 8'd16;
  localparam logic [7:0] STR_BASE_B     = 8'd17;
  localparam logic [7:0] STR_BASE_C     = 8'd18;
  localparam logic [7:0] STR_LENGTH     = 8'd19;

  logic        clk = 1'b0;
  logic        rst_n_i;
  logic [7:0]  csr_addr_i;
  logic [31:0] csr_wdata_i;
  logic        csr_write_i;
  logic        csr_req_valid_i;
  logic        csr_req_ready_o;
  logic [31:0] csr_rsp_data_o;
  logic        csr_rsp_valid_o;
  logic        csr_rsp_ready_i = 1'b0;
  logic        tcdm_req_valid_o;
  logic        tcdm_req_ready_i = 1'b0;
  logic        tcdm_write_o;
  logic [11:0] tcdm_addr_o;
  logic [31:0] tcdm_wdata_o;
  logic        tcdm_rsp_valid_i = 1'b0;
  logic [31:0] tcdm_rsp_data_i = 32'h0;

  logic [31:0] mem [0:MEM_WORDS-1];
  // Contents before any job ran
  logic [31:0] init_mem [0:MEM_WORDS-1];
  logic [31:0] stim [0:NUM_JOBS*NUM_FIELDS-1];
  integer      seed = 32'h3e2ffb7a;
  int          env_rnd;
  logic        mem_loaded = 1'b0;
  logic        rd_pend = 1'b0;
  logic [31:0] rd_word = 32'h0;
  int          wr_count = 0;
  int          req_seen = 0;
  int          rsp_seen = 0;
  int          errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          watch_cycles = 0;

  always #5 clk = ~clk;

  simba_top UUT (
    .clk_i            ( clk              ),
    .rst_n_i          ( rst_n_i          ),
    .csr_addr_i       ( csr_addr_i       ),
    .csr_wdata_i      ( csr_wdata_i      ),
    .csr_write_i      ( csr_write_i      ),
    .csr_req_valid_i  ( csr_req_valid_i  ),
    .csr_req_ready_o  ( csr_req_ready_o  ),
    .csr_rsp_data_o   ( csr_rsp_data_o   ),
    .csr_rsp_valid_o  ( csr_rsp_valid_o  ),
    .csr_rsp_ready_i  ( csr_rsp_ready_i  ),
    .tcdm_req_valid_o ( tcdm_req_valid_o ),
    .tcdm_req_ready_i ( tcdm_req_ready_i ),
    .tcdm_write_o     ( tcdm_write_o     ),
    .tcdm_addr_o      ( tcdm_addr_o      ),
    .tcdm_wdata_o     ( tcdm_wdata_o     ),
    .tcdm_rsp_valid_i ( tcdm_rsp_valid_i ),
    .tcdm_rsp_data_i  ( tcdm_rsp_data_i  )
  );

  // --------------------
  // TCDM model and random back-pressure
  // --------------------
  always @(negedge clk) begin
    // Random fill once during reset
    if (!mem_loaded) begin
      for (int a = 0; a < MEM_WORDS; a++) begin
        mem[a]      = $random(seed);
        init_mem[a] = mem[a];
      end
      mem_loaded = 1'b1;
    end
    // Answer the read taken at the last rising edge
    tcdm_rsp_valid_i = rd_pend;
    tcdm_rsp_data_i  = rd_pend ? rd_word : 32'h0;
    rd_pend          = 1'b0;
    env_rnd          = $random(seed);
    // Grant three times in four
    tcdm_req_ready_i = rst_n_i && (env_rnd[1:0] != 2'b00);
    csr_rsp_ready_i  = env_rnd[2] | env_rnd[3];
    // Registered request outputs give the transfer at the next rising edge
    if (tcdm_req_valid_o && tcdm_req_ready_i) begin
      if (tcdm_write_o) begin
        mem[tcdm_addr_o] = tcdm_wdata_o;
        wr_count++;
      end else begin
        rd_pend = 1'b1;
        rd_word = mem[tcdm_addr_o];
      end
    end
  end

  // Host handshakes counted mid cycle
  always @(negedge clk) begin
    #2;
    if (csr_req_valid_i && csr_req_ready_o) req_seen++;
    if (csr_rsp_valid_o && csr_rsp_ready_i) rsp_seen++;
  end

  // Watchdog
  initial begin
    wait (watch_cycles > 0);
    repeat (watch_cycles) @(posedge clk);
    $display("Timeout: run did not end within %0d cycles", watch_cycles);
    $display("Test failures found");
    $finish;
  end

  // --------------------
  // Helpers
  // --------------------
  task automatic report_mismatch(input string sig, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("[FAIL] %s: got 0x%h, expected 0x%h", sig, got, exp);
    errors++;
  endtask

  task automatic report_problem(input string msg);
    $display("Error: %s", msg);
    errors++;
  endtask

  // One host transfer through both handshakes
  task automatic access_csr(input logic wr, input logic [7:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    @(negedge clk);
    csr_addr_i      = addr;
    csr_wdata_i     = wdata;
    csr_write_i     = wr;
    csr_req_valid_i = 1'b1;
    // Ready settles once the address is driven
    #1;
    while (!csr_req_ready_o) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    csr_req_valid_i = 1'b0;
    #1;
    while (!(csr_rsp_valid_o && csr_rsp_ready_i)) begin
      @(negedge clk);
      #1;
    end
    rdata = csr_rsp_data_o;
  endtask

  task automatic write_csr(input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] rsp;
    access_csr(1'b1, addr, data, rsp);
    if (rsp !== 32'h0) report_mismatch("csr_rsp_data_o on write", rsp, 32'h0);
  endtask

  task automatic expect_csr(input logic [7:0] addr, input logic [31:0] exp,
                            input string name);
    logic [31:0] rd;
    access_csr(1'b0, addr, 32'h0, rd);
    if (rd !== exp) report_mismatch($sformatf("csr_rsp_data_o %s", name), rd, exp);
  endtask

  // Low word of the 64-bit product shifted right
  function automatic logic [31:0] expected_result(input logic [31:0] a,
                                                  input logic [31:0] b,
                                                  input logic [4:0] sh);
    logic [63:0] p;
    p = {32'h0, a} * {32'h0, b};
    p = p >> sh;
    return p[31:0];
  endfunction

  task automatic finish_test(input string name, input int errs_before);
    // Let the handshake monitor catch up
    repeat (2) @(negedge clk);
    if (req_seen != rsp_seen) begin
      report_problem($sformatf("%0d CSR requests got %0d responses", req_seen, rsp_seen));
    end
    tests_run++;
    if (errors != errs_before) tests_failed++;
    $display("test %0d %s: %s", tests_run, name, (errors == errs_before) ? "ok" : "FAILED");
  endtask

  // --------------------
  // Tests
  // --------------------
  task automatic check_csr_map();
    int errs0;
    errs0 = errors;
    write_csr(STR_BASE_A, 32'hdead_beef);
    write_csr(STR_BASE_B, 32'h0123_4567);
    write_csr(STR_BASE_C, 32'h89ab_cdef);
    write_csr(STR_LENGTH, 32'h0000_0fff);
    // Only five bits of SHIFT are kept
    write_csr(MGR_SHIFT, 32'hffff_ffe3);
    expect_csr(STR_BASE_A, 32'hdead_beef, "BASE_A");
    expect_csr(STR_BASE_B, 32'h0123_4567, "BASE_B");
    expect_csr(STR_BASE_C, 32'h89ab_cdef, "BASE_C");
    expect_csr(STR_LENGTH, 32'h0000_0fff, "LENGTH");
    expect_csr(MGR_SHIFT, 32'h0000_0003, "SHIFT");
    // Unmapped indices on both sides
    expect_csr(8'd4, 32'h0, "manager index 4");
    expect_csr(8'd15, 32'h0, "manager index 15");
    expect_csr(8'd20, 32'h0, "streamer index 4");
    expect_csr(8'hff, 32'h0, "streamer index 239");
    finish_test("csr read-back", errs0);
  endtask

  task automatic run_job(input int j);
    logic [31:0] base_a;
    logic [31:0] base_b;
    logic [31:0] base_c;
    logic [31:0] len;
    logic [31:0] shift_wr;
    logic [31:0] shift_rb;
    logic [31:0] twice;
    logic [31:0] rd;
    logic [31:0] exp;
    logic [11:0] a_addr;
    logic [11:0] b_addr;
    logic [11:0] c_addr;
    int          errs0;
    int          wr0;
    int          i;
    errs0    = errors;
    base_a   = stim[j*NUM_FIELDS];
    base_b   = stim[j*NUM_FIELDS+1];
    base_c   = stim[j*NUM_FIELDS+2];
    len      = stim[j*NUM_FIELDS+3];
    shift_wr = stim[j*NUM_FIELDS+4];
    shift_rb = stim[j*NUM_FIELDS+5];
    twice    = stim[j*NUM_FIELDS+6];
    write_csr(STR_BASE_A, base_a);
    write_csr(STR_BASE_B, base_b);
    write_csr(STR_BASE_C, base_c);
    write_csr(STR_LENGTH, len);
    write_csr(MGR_SHIFT, shift_wr);
    expect_csr(STR_BASE_A, base_a, "BASE_A");
    expect_csr(STR_BASE_B, base_b, "BASE_B");
    expect_csr(STR_BASE_C, base_c, "BASE_C");
    expect_csr(STR_LENGTH, len, "LENGTH");
    expect_csr(MGR_SHIFT, shift_rb, "SHIFT");
    // One completion per earlier job
    expect_csr(MGR_DONE_COUNT, 32'(j), "DONE_COUNT before start");
    wr0 = wr_count;
    write_csr(MGR_CTRL, 32'h1);
    // Second start lands while busy and must be dropped
    if (twice[0]) write_csr(MGR_CTRL, 32'h1);
    if (len != 32'h0) expect_csr(MGR_STATUS, 32'h1, "STATUS after start");
    // Poll busy until the job ends
    do begin
      access_csr(1'b0, MGR_STATUS, 32'h0, rd);
    end while (rd[0]);
    if (rd !== 32'h0) report_mismatch("csr_rsp_data_o STATUS at end", rd, 32'h0);
    // Quiet gap so a stray second job would show
    repeat (10) @(negedge clk);
    expect_csr(MGR_DONE_COUNT, 32'(j + 1), "DONE_COUNT");
    if (wr_count - wr0 != int'(len)) begin
      report_problem($sformatf("job %0d wrote %0d TCDM words instead of %0d",
                               j, wr_count - wr0, len));
    end
    for (i = 0; i < int'(len); i++) begin
      a_addr = base_a[11:0] + 12'(i);
      b_addr = base_b[11:0] + 12'(i);
      c_addr = base_c[11:0] + 12'(i);
      exp    = expected_result(init_mem[a_addr], init_mem[b_addr], shift_rb[4:0]);
      if (mem[c_addr] !== exp) begin
        report_mismatch($sformatf("tcdm_wdata_o to C[%0d]", i), mem[c_addr], exp);
      end
    end
    // Word just past C untouched
    c_addr = base_c[11:0] + len[11:0];
    if (mem[c_addr] !== init_mem[c_addr]) begin
      report_mismatch("TCDM word past C", mem[c_addr], init_mem[c_addr]);
    end
    finish_test($sformatf("job %0d, length %0d", j, len), errs0);
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    int total;
    rst_n_i         = 1'b0;
    csr_addr_i      = 8'h0;
    csr_wdata_i     = 32'h0;
    csr_write_i     = 1'b0;
    csr_req_valid_i = 1'b0;
    $readmemh("tests/simba_stimulus.txt", stim);
    total = 0;
    for (int j = 0; j < NUM_JOBS; j++) begin
      total += int'(stim[j*NUM_FIELDS+3]);
    end
    watch_cycles = MARGIN_CYCLES + CYCLES_PER_ELEM * total;
    repeat (3) @(negedge clk);
    rst_n_i = 1'b1;
    check_csr_map();
    for (int j = 0; j < NUM_JOBS; j++) begin
      run_job(j);
    end
    $display("%0d tests run, %0d passed, %0d failed, %0d errors",
             tests_run, tests_run - tests_failed, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+verilog
verilog/simba_pkg.sv
verilog/csr_bus_if.sv
verilog/csr_demux.sv
verilog/csr_manager.sv
verilog/tcdm_streamer.sv
verilog/mul_core.sv
verilog/simba_top.sv
tests/simba_tb.sv

// ==== Makefile ====
TOP := simba_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/10ps -f compile.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

// ==== tests/simba_stimulus.txt ====
// One job per line, hex: base_a base_b base_c length shift_written shift_readback start_twice
// shift_readback is the 5-bit SHIFT field, the shift the core applies
000 040 080 0a 00 00 0
100 140 180 14 08 08 1
200 240 280 00 10 10 0
300 340 380 11 3f 1f 0
400 440 480 20 25 05 1
ff8 500 580 10 0c 0c 0
